/* issue_ctrl.f */
+incdir+verilog
verilog/rv_issue_pkg.sv
verilog/op_decoder.sv
verilog/scoreboard.sv
verilog/exec_pipe.sv
verilog/wb_arbiter.sv
verilog/issue_ctrl.sv
tb/tb_issue_ctrl.sv

/* Bender.yml */
package:
  name: issue_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_issue_pkg.sv
      - verilog/op_decoder.sv
      - verilog/scoreboard.sv
      - verilog/exec_pipe.sv
      - verilog/wb_arbiter.sv
      - verilog/issue_ctrl.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/tb_issue_ctrl.sv

/* tb/tb_issue_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_params.svh"

module tb_issue_ctrl;

	logic clk;
	logic nrst;
	logic instr_valid;
	logic [6:0] op_code;
	logic [`REG_W-1:0] rd;
	logic [`REG_W-1:0] rs1;
	logic [`REG_W-1:0] rs2;
	logic [`XLEN-1:0] wdata;
	logic btaken;
	logic stall;
	logic kill;
	rv_issue_pkg::wb_req_t wb;

	// reference model, advanced once per cycle at the falling edge
	logic [`NUM_REGS-1:0] m_pend;
	rv_issue_pkg::wb_req_t m_alu [`ALU_LAT];
	rv_issue_pkg::wb_req_t m_mem [`MEM_LAT];
	rv_issue_pkg::wb_req_t m_wb;	// what wb shows next cycle
	logic m_kill;
	logic m_hold;	// presented instruction stalls this cycle

	logic [31:0] lfsr;
	int errors;
	int tests;
	int writes;
	int issued;
	int err_start;
	int wr_start;
	int is_start;

	issue_ctrl i_issue_ctrl
	(
		.clk(clk),
		.nrst(nrst),
		.instr_valid(instr_valid),
		.op_code(op_code),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.wdata(wdata),
		.btaken(btaken),
		.stall(stall),
		.kill(kill),
		.wb(wb)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			r = {r[30:0], lfsr[31]};
			lfsr = {lfsr[30:0], fb};
		end
		return r;
	endfunction

	function automatic logic [6:0] pick_op();
		case (rand_bits(4) % 10)
			0: return 7'b0110111;	// lui
			1: return 7'b0010111;	// auipc
			2: return 7'b1101111;	// jal
			3: return 7'b1100111;	// jalr
			4: return 7'b0010011;	// addi
			5: return 7'b1100011;	// branch
			6: return 7'b0000011;	// load
			7: return 7'b0100011;	// store
			8: return 7'b0110011;	// add
			default: return 7'b0000000;	// not an rv32i opcode
		endcase
	endfunction

	// rv32i operand use as {rs1, rs2, rd, load}
	function automatic logic [3:0] op_use(input logic [6:0] op);
		case (op)
			7'b0110111, 7'b0010111, 7'b1101111: return 4'b0010;
			7'b1100111, 7'b0010011: return 4'b1010;
			7'b1100011, 7'b0100011: return 4'b1100;
			7'b0000011: return 4'b1011;
			7'b0110011: return 4'b1110;
			default: return 4'b0000;
		endcase
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		errors++;
		$display("mismatch at %0t: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
	endtask

	always @(negedge clk)
	begin : model_step
		logic [3:0] u;
		logic writer;
		logic hazard;
		logic busy;
		logic exp_stall;
		logic accept;
		logic mem_g;
		logic alu_g;
		logic alu_shift;
		if (!nrst)
		begin
			m_pend = '0;
			for (int i = 0; i < `ALU_LAT; i++)
				m_alu[i] = '0;
			for (int i = 0; i < `MEM_LAT; i++)
				m_mem[i] = '0;
			m_wb = '0;
			m_kill = 1'b0;
			m_hold = 1'b0;
		end
		else
		begin
			u = op_use(op_code);
			mem_g = m_mem[`MEM_LAT-1].valid;	// load pipe has priority
			alu_g = m_alu[`ALU_LAT-1].valid && !mem_g;
			alu_shift = alu_g || !m_alu[`ALU_LAT-1].valid;
			writer = u[1] && (rd != '0);
			hazard = (u[3] && m_pend[rs1]) || (u[2] && m_pend[rs2]) || (writer && m_pend[rd]);
			busy = writer && !u[0] && !alu_shift;	// load head is never refused
			exp_stall = instr_valid && (hazard || busy || m_kill);
			accept = instr_valid && !exp_stall;

			if (stall !== exp_stall)
				report_value("stall", exp_stall, stall);
			if (kill !== m_kill)
				report_value("kill", m_kill, kill);
			if (wb.valid !== m_wb.valid)
				report_value("wb.valid", m_wb.valid, wb.valid);
			else if (m_wb.valid && wb.rd !== m_wb.rd)
				report_value("wb.rd", m_wb.rd, wb.rd);
			else if (m_wb.valid && wb.data !== m_wb.data)
				report_value("wb.data", m_wb.data, wb.data);
			if (wb.valid === 1'b1 && wb.rd == '0)
			begin
				errors++;
				$display("register 0 was written at %0t", $time);
			end
			if (wb.valid === 1'b1)
				writes++;

			m_hold = exp_stall;
			m_kill = btaken;
			m_wb = '0;
			if (mem_g)
				m_wb = m_mem[`MEM_LAT-1];
			else if (alu_g)
				m_wb = m_alu[`ALU_LAT-1];
			if (m_wb.valid)
				m_pend[m_wb.rd] = 1'b0;
			if (accept && writer)
			begin
				m_pend[rd] = 1'b1;
				issued++;
			end
			for (int i = `MEM_LAT-1; i > 0; i--)
				m_mem[i] = m_mem[i-1];
			m_mem[0] = '{valid: accept && writer && u[0], rd: rd, data: wdata};
			if (alu_shift)
			begin
				for (int i = `ALU_LAT-1; i > 0; i--)
					m_alu[i] = m_alu[i-1];
				m_alu[0] = '{valid: accept && writer && !u[0], rd: rd, data: wdata};
			end
		end
	end

	task automatic start_test();
		err_start = errors;
		wr_start = writes;
		is_start = issued;
	endtask

	task automatic summarize_test(input string name);
		tests++;
		if (errors == err_start)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - err_start);
	endtask

	// wait until nothing is pending and no write is on its way
	task automatic drain(input string what);
		int n;
		n = 0;
		@(posedge clk);
		while ((m_pend != '0 || m_wb.valid) && n < 50)
		begin
			@(posedge clk);
			n++;
		end
		if (n >= 50)
		begin
			errors++;
			$display("timeout at %0t while %s did not drain", $time, what);
		end
	endtask

	task automatic present(input logic [6:0] op, input logic [`REG_W-1:0] dst,
		input logic [`XLEN-1:0] d);
		instr_valid <= 1'b1;
		op_code <= op;
		rd <= dst;
		rs1 <= '0;
		rs2 <= '0;
		wdata <= d;
	endtask

	task automatic check_latency(input logic [6:0] op, input logic [`REG_W-1:0] dst, input int lat);
		int n;
		@(posedge clk);
		present(op, dst, rand_bits(32));
		@(posedge clk);	// accepted on this edge
		instr_valid <= 1'b0;
		@(negedge clk);
		n = 0;
		while (wb.valid !== 1'b1 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 20)
		begin
			errors++;
			$display("timeout at %0t, no writeback for register %0d", $time, dst);
		end
		else if (n != lat)
			report_value("latency", lat, n);
		drain("latency test");
	endtask

	task automatic check_priority();
		int n;
		@(posedge clk);
		present(7'b0000011, 5'd10, rand_bits(32));	// load
		@(posedge clk);
		instr_valid <= 1'b0;
		@(posedge clk);
		present(7'b0010011, 5'd11, rand_bits(32));	// addi, heads meet
		@(posedge clk);
		instr_valid <= 1'b0;
		n = 0;
		@(negedge clk);
		while (wb.valid !== 1'b1 && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (n >= 20)
		begin
			errors++;
			$display("timeout at %0t, no writeback in priority test", $time);
		end
		else
		begin
			if (wb.rd !== 5'd10)
				report_value("first wb.rd", 10, wb.rd);
			@(negedge clk);
			if (wb.valid !== 1'b1 || wb.rd !== 5'd11)
				report_value("second wb.rd", 11, wb.rd);
		end
		drain("priority test");
	endtask

	task automatic check_kill();
		@(posedge clk);
		btaken <= 1'b1;
		@(posedge clk);	// kill rises here
		btaken <= 1'b0;
		present(7'b0000000, 5'd0, '0);	// no-op
		@(negedge clk);
		if (kill !== 1'b1)
			report_value("kill", 1, kill);
		if (stall !== 1'b1)
			report_value("stall during kill", 1, stall);
		@(posedge clk);
		@(negedge clk);
		if (kill !== 1'b0)
			report_value("kill", 0, kill);
		if (stall !== 1'b0)
			report_value("stall after kill", 0, stall);
		@(posedge clk);
		instr_valid <= 1'b0;
	endtask

	task automatic run_random(input int cycles);
		for (int c = 0; c < cycles; c++)
		begin
			@(posedge clk);
			if (!m_hold)
			begin
				instr_valid <= (rand_bits(2) != '0);
				op_code <= pick_op();
				rd <= `REG_W'(rand_bits(3));	// few registers, many hazards
				rs1 <= `REG_W'(rand_bits(3));
				rs2 <= `REG_W'(rand_bits(3));
				wdata <= rand_bits(32);
			end
			btaken <= (rand_bits(4) == 32'hf);
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		btaken <= 1'b0;
		drain("random stream");
		if (writes - wr_start != issued - is_start)
			report_value("writeback count", issued - is_start, writes - wr_start);
	endtask

	initial
	begin
		lfsr = 32'h38d8_2d69;
		errors = 0;
		tests = 0;
		writes = 0;
		issued = 0;
		nrst = 1'b0;
		instr_valid = 1'b0;
		op_code = '0;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		wdata = '0;
		btaken = 1'b0;
		repeat (8) @(posedge clk);
		nrst <= 1'b1;

		start_test();
		repeat (4)
		begin
			@(negedge clk);
			if (stall !== 1'b0)
				report_value("stall", 0, stall);
			if (kill !== 1'b0)
				report_value("kill", 0, kill);
			if (wb.valid !== 1'b0)
				report_value("wb.valid", 0, wb.valid);
		end
		if (writes != wr_start)
			report_value("writes after reset", 0, writes - wr_start);
		summarize_test("reset");

		start_test();
		check_latency(7'b0010011, 5'd5, `ALU_LAT);
		check_latency(7'b0000011, 5'd6, `MEM_LAT);
		summarize_test("latency");

		start_test();
		check_priority();
		summarize_test("priority");

		start_test();
		check_kill();
		summarize_test("kill");

		start_test();
		run_random(400);
		summarize_test("random");

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/issue_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_params.svh"

module issue_ctrl
(
	input wire logic clk,
	input wire logic nrst,
	input wire logic instr_valid,
	input wire logic [6:0] op_code,
	input wire logic [`REG_W-1:0] rd,
	input wire logic [`REG_W-1:0] rs1,
	input wire logic [`REG_W-1:0] rs2,
	input wire logic [`XLEN-1:0] wdata,
	input wire logic btaken,
	output logic stall,
	output logic kill,
	output rv_issue_pkg::wb_req_t wb
);

	rv_issue_pkg::dec_t dec;
	rv_issue_pkg::wb_req_t alu_in, mem_in;
	rv_issue_pkg::wb_req_t alu_out, mem_out;
	rv_issue_pkg::wb_req_t clr;
	logic issue;
	logic alu_ready, mem_ready;
	logic alu_grant, mem_grant;

	// steer the issued writer by class
	assign alu_in = '{valid: issue && !dec.to_mem, rd: rd, data: wdata};
	assign mem_in = '{valid: issue && dec.to_mem, rd: rd, data: wdata};

	op_decoder i_op_decoder
	(
		.op_code(op_code),
		.dec(dec)
	);

	scoreboard i_scoreboard
	(
		.clk(clk),
		.nrst(nrst),
		.instr_valid(instr_valid),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.dec(dec),
		.alu_ready(alu_ready),
		.mem_ready(mem_ready),
		.btaken(btaken),
		.clr(clr),
		.stall(stall),
		.kill(kill),
		.issue(issue)
	);

	exec_pipe #(.DEPTH(`ALU_LAT)) i_alu_pipe
	(
		.clk(clk),
		.nrst(nrst),
		.in_req(alu_in),
		.grant(alu_grant),
		.out_req(alu_out),
		.ready(alu_ready)
	);

	exec_pipe #(.DEPTH(`MEM_LAT)) i_mem_pipe
	(
		.clk(clk),
		.nrst(nrst),
		.in_req(mem_in),
		.grant(mem_grant),
		.out_req(mem_out),
		.ready(mem_ready)
	);

	wb_arbiter i_wb_arbiter
	(
		.clk(clk),
		.nrst(nrst),
		.alu_req(alu_out),
		.mem_req(mem_out),
		.alu_grant(alu_grant),
		.mem_grant(mem_grant),
		.clr(clr),
		.wb(wb)
	);

endmodule

`default_nettype wire

/* verilog/wb_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module wb_arbiter
(
	input wire logic clk,
	input wire logic nrst,
	input wire rv_issue_pkg::wb_req_t alu_req,
	input wire rv_issue_pkg::wb_req_t mem_req,
	output logic alu_grant,
	output logic mem_grant,
	output rv_issue_pkg::wb_req_t clr,
	output rv_issue_pkg::wb_req_t wb
);

	// load pipe always wins
	assign mem_grant = mem_req.valid;
	assign alu_grant = alu_req.valid && !mem_req.valid;

	// granted request also frees the scoreboard bit
	assign clr = mem_grant ? mem_req : (alu_grant ? alu_req : '0);

	always_ff @(posedge clk)
	begin
		if (!nrst)
			wb.valid <= 1'b0;
		else
			wb <= clr;	// single rf write port
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!nrst)
		!(alu_grant && mem_grant));

endmodule

`default_nettype wire

/* verilog/exec_pipe.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_pipe
#(
	parameter int DEPTH = 2
)
(
	input wire logic clk,
	input wire logic nrst,
	input wire rv_issue_pkg::wb_req_t in_req,
	input wire logic grant,
	output rv_issue_pkg::wb_req_t out_req,
	output logic ready
);

	rv_issue_pkg::wb_req_t stage [DEPTH];
	logic shift;

	assign out_req = stage[DEPTH-1];

	// advance when the head drains or is empty
	assign shift = grant || !stage[DEPTH-1].valid;
	assign ready = shift;

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < DEPTH; i++)
				stage[i].valid <= 1'b0;
		end
		else if (shift)
		begin
			stage[0] <= in_req;
			for (int i = 1; i < DEPTH; i++)
				stage[i] <= stage[i-1];
		end
	end

	// a losing head waits for the arbiter with its payload intact
	a_head_hold: assert property (@(posedge clk) disable iff (!nrst)
		(out_req.valid && !grant) |=> (out_req.valid && $stable(out_req)));

	// issue only enters a moving pipe
	a_no_push_frozen: assert property (@(posedge clk) disable iff (!nrst)
		!shift |-> !in_req.valid);

endmodule

`default_nettype wire

/* verilog/scoreboard.sv */
`timescale 1ns/1ns
`default_nettype none

`include "issue_params.svh"

module scoreboard
(
	input wire logic clk,
	input wire logic nrst,
	input wire logic instr_valid,
	input wire logic [`REG_W-1:0] rd,
	input wire logic [`REG_W-1:0] rs1,
	input wire logic [`REG_W-1:0] rs2,
	input wire rv_issue_pkg::dec_t dec,
	input wire logic alu_ready,
	input wire logic mem_ready,
	input wire logic btaken,
	input wire rv_issue_pkg::wb_req_t clr,
	output logic stall,
	output logic kill,
	output logic issue
);

	logic [`NUM_REGS-1:0] pending;	// one bit per architectural register
	logic writer;
	logic src_hazard;
	logic dst_hazard;
	logic pipe_busy;

	assign writer = dec.writes_rd && (rd != '0);	// x0 writes are dropped

	// raw on either used source
	assign src_hazard = (dec.uses_rs1 && pending[rs1]) || (dec.uses_rs2 && pending[rs2]);
	assign dst_hazard = writer && pending[rd];	// waw
	assign pipe_busy = writer && (dec.to_mem ? !mem_ready : !alu_ready);

	assign stall = instr_valid && (src_hazard || dst_hazard || pipe_busy || kill);
	assign issue = instr_valid && !stall && writer;

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			pending <= '0;
			kill <= 1'b0;
		end
		else
		begin
			kill <= btaken;	// one cycle after the branch resolves
			if (clr.valid)
				pending[clr.rd] <= 1'b0;
			// issue never targets a pending rd, so no clash with the clear
			if (issue)
				pending[rd] <= 1'b1;
		end
	end

	// x0 must never look busy
	a_x0_free: assert property (@(posedge clk) disable iff (!nrst)
		!pending[0]);

	// every granted writeback belongs to an outstanding writer
	a_clr_pending: assert property (@(posedge clk) disable iff (!nrst)
		clr.valid |-> pending[clr.rd]);

endmodule

`default_nettype wire

/* verilog/op_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module op_decoder
(
	input wire logic [6:0] op_code,
	output rv_issue_pkg::dec_t dec
);

	rv_issue_pkg::op_class_e op_class;

	// opcode to class
	always_comb
	begin
		unique case (op_code)
			7'b0110111: op_class = rv_issue_pkg::op_upper;	// lui
			7'b0010111: op_class = rv_issue_pkg::op_upper;	// auipc
			7'b1101111: op_class = rv_issue_pkg::op_upper;	// jal
			7'b1100111: op_class = rv_issue_pkg::op_imm;	// jalr
			7'b0010011: op_class = rv_issue_pkg::op_imm;	// addi and friends
			7'b1100011: op_class = rv_issue_pkg::op_branch;
			7'b0000011: op_class = rv_issue_pkg::op_load;
			7'b0100011: op_class = rv_issue_pkg::op_store;
			7'b0110011: op_class = rv_issue_pkg::op_reg;	// add and friends
			default: op_class = rv_issue_pkg::op_none;
		endcase
	end

	// class to operand usage
	always_comb
	begin
		dec.op_class = op_class;
		dec.uses_rs1 = 1'b0;
		dec.uses_rs2 = 1'b0;
		dec.writes_rd = 1'b0;
		dec.to_mem = 1'b0;
		case (op_class)
			rv_issue_pkg::op_upper:
				dec.writes_rd = 1'b1;	// no source operands
			rv_issue_pkg::op_imm:
			begin
				dec.uses_rs1 = 1'b1;
				dec.writes_rd = 1'b1;
			end
			rv_issue_pkg::op_branch, rv_issue_pkg::op_store:
			begin
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
			end
			rv_issue_pkg::op_load:
			begin
				dec.uses_rs1 = 1'b1;
				dec.writes_rd = 1'b1;
				dec.to_mem = 1'b1;	// long latency pipe
			end
			rv_issue_pkg::op_reg:
			begin
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
				dec.writes_rd = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rv_issue_pkg.sv */
`default_nettype none

`include "issue_params.svh"

package rv_issue_pkg;

	// operation class of an RV32I instruction
	typedef enum logic [2:0]
	{
		op_none,	// unknown opcode, issues as a no-op
		op_upper,	// lui, auipc, jal
		op_imm,		// jalr, addi-type
		op_branch,
		op_load,
		op_store,
		op_reg		// register-register alu
	} op_class_e;

	// decoded instruction, shared by scoreboard and routing
	typedef struct packed
	{
		op_class_e op_class;
		logic uses_rs1;
		logic uses_rs2;
		logic writes_rd;
		logic to_mem;	// route to load pipe
	} dec_t;

	// one register file write
	typedef struct packed
	{
		logic valid;
		logic [`REG_W-1:0] rd;
		logic [`XLEN-1:0] data;
	} wb_req_t;

endpackage

`default_nettype wire

/* verilog/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// architectural register file
`define NUM_REGS 32
`define REG_W 5

// data path width
`define XLEN 32

// execution pipe depths, cycles from acceptance to wb
`define ALU_LAT 2
`define MEM_LAT 4

`endif
